//--- flist.f
source/sb_pkg.sv
source/sb_ctrl.sv
source/sb_entry_store.sv
source/sb_clobber.sv
source/sb_operand_fwd.sv
source/scoreboard.sv
tb/tb_scoreboard.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_scoreboard
FLIST = flist.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- tb/tb_scoreboard.sv
// scoreboard testbench
// directed tests for allocation, back-pressure, write-back, commit and flush
`timescale 1ns/100ps

module tb_scoreboard;

  localparam int unsigned NR_ENTRIES = 8;
  localparam int unsigned NR_WB_PORTS = 2;
  localparam int unsigned ID_W = $clog2(NR_ENTRIES);
  localparam int CLK_PERIOD = 20;
  // the six tests run in about 40 cycles and the limit leaves wide margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic clk_i, rst_ni;
  logic decoded_valid_i, decoded_ack_o, issue_valid_o, issue_ack_i, unresolved_branch_i;
  sb_pkg::fu_t decoded_fu_i, issue_fu_o, commit_fu_o;
  sb_pkg::reg_addr_t decoded_rd_i, issue_rd_o, commit_rd_o, rs1_i, rs2_i;
  logic [ID_W-1:0] issue_trans_id_o, commit_trans_id_o;
  logic [NR_WB_PORTS-1:0] wb_valid_i;
  logic [NR_WB_PORTS-1:0][ID_W-1:0] wb_trans_id_i;
  sb_pkg::data_t [NR_WB_PORTS-1:0] wb_data_i;
  logic commit_valid_o, commit_ack_i, rs1_valid_o, rs2_valid_o;
  sb_pkg::data_t commit_result_o, rs1_o, rs2_o;
  sb_pkg::fu_t [sb_pkg::NR_REGS-1:0] rd_clobber_o;
  logic sb_full_o, flush_i, flush_unissued_i;

  int seed = 32'h334eb66b;
  int errors = 0;
  int cycles = 0;

  scoreboard #(.NR_ENTRIES(NR_ENTRIES), .NR_WB_PORTS(NR_WB_PORTS)) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // run limit so a stuck handshake ends the run
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: no handshake completed within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------
  function automatic sb_pkg::data_t rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // every register free of pending writers
  task automatic check_all_free(input string name);
    for (int r = 0; r < int'(sb_pkg::NR_REGS); r++) begin
      check(name, 64'(sb_pkg::FU_NONE), 64'(rd_clobber_o[r]));
    end
  endtask

  // offer one instruction, wait for issue_valid_o, then acknowledge it
  task automatic issue_op(input sb_pkg::fu_t fu, input sb_pkg::reg_addr_t rd,
                          output logic [ID_W-1:0] id);
    decoded_valid_i = 1'b1;
    decoded_fu_i = fu;
    decoded_rd_i = rd;
    #1;
    while (!issue_valid_o) begin
      @(negedge clk_i);
      #1;
    end
    // decoded instruction passes through to the issue stage
    check("issue_fu", 64'(fu), 64'(issue_fu_o));
    check("issue_rd", 64'(rd), 64'(issue_rd_o));
    issue_ack_i = 1'b1;
    #1;
    check("issue_ack", 64'(1), 64'(decoded_ack_o));
    id = issue_trans_id_o;
    @(negedge clk_i);
    decoded_valid_i = 1'b0;
    issue_ack_i = 1'b0;
  endtask

  // wait for the oldest entry, compare it, then free it
  task automatic commit_op(input string name, input logic [ID_W-1:0] id, input sb_pkg::fu_t fu,
                           input sb_pkg::reg_addr_t rd, input logic has_result,
                           input sb_pkg::data_t result);
    #1;
    while (!commit_valid_o) begin
      @(negedge clk_i);
      #1;
    end
    check(name, 64'(id), 64'(commit_trans_id_o));
    check(name, 64'(fu), 64'(commit_fu_o));
    check(name, 64'(rd), 64'(commit_rd_o));
    // self-completed entries carry no result
    if (has_result) check(name, result, commit_result_o);
    commit_ack_i = 1'b1;
    @(negedge clk_i);
    commit_ack_i = 1'b0;
  endtask

  task automatic drive_wb(input int port, input logic [ID_W-1:0] id, input sb_pkg::data_t data);
    wb_valid_i[port] = 1'b1;
    wb_trans_id_i[port] = id;
    wb_data_i[port] = data;
  endtask

  // ---------------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------------
  task automatic test_reset();
    #1;
    check("reset", 64'(0), 64'({issue_valid_o, decoded_ack_o, commit_valid_o, sb_full_o}));
    check_all_free("reset");
  endtask

  task automatic test_alloc();
    logic [ID_W-1:0] id;
    issue_op(sb_pkg::FU_ALU, 5'd3, id);
    check("alloc", 64'(0), 64'(id));
    issue_op(sb_pkg::FU_LSU, 5'd4, id);
    check("alloc", 64'(1), 64'(id));
    issue_op(sb_pkg::FU_MULT, 5'd5, id);
    check("alloc", 64'(2), 64'(id));
    check("clobber", 64'(sb_pkg::FU_ALU), 64'(rd_clobber_o[3]));
    check("clobber", 64'(sb_pkg::FU_LSU), 64'(rd_clobber_o[4]));
    check("clobber", 64'(sb_pkg::FU_MULT), 64'(rd_clobber_o[5]));
    // x0 destination never shows as busy
    issue_op(sb_pkg::FU_ALU, 5'd0, id);
    check("alloc", 64'(3), 64'(id));
    check("clobber_x0", 64'(sb_pkg::FU_NONE), 64'(rd_clobber_o[0]));
  endtask

  task automatic test_full();
    logic [ID_W-1:0] id;
    sb_pkg::data_t d0;
    d0 = rand_data();
    issue_op(sb_pkg::FU_NONE, 5'd6, id);
    check("full_alloc", 64'(4), 64'(id));
    issue_op(sb_pkg::FU_ALU, 5'd9, id);
    check("full_alloc", 64'(5), 64'(id));
    issue_op(sb_pkg::FU_NONE, 5'd7, id);
    check("full_alloc", 64'(6), 64'(id));
    // seven outstanding leave the last slot empty
    decoded_valid_i = 1'b1;
    decoded_fu_i = sb_pkg::FU_ALU;
    decoded_rd_i = 5'd12;
    repeat (2) begin
      #1;
      check("full", 64'(1), 64'(sb_full_o));
      check("full_stall", 64'(0), 64'({issue_valid_o, decoded_ack_o}));
      @(negedge clk_i);
    end
    decoded_valid_i = 1'b0;
    drive_wb(0, 3'd0, d0);
    @(negedge clk_i);
    wb_valid_i = '0;
    commit_op("full_commit", 3'd0, sb_pkg::FU_ALU, 5'd3, 1'b1, d0);
    #1;
    check("full_release", 64'(0), 64'(sb_full_o));
  endtask

  task automatic test_writeback();
    sb_pkg::data_t d1, d2, d3, d5;
    d1 = rand_data();
    d2 = rand_data();
    d3 = rand_data();
    d5 = rand_data();
    @(negedge clk_i);
    rs1_i = 5'd4;
    #1;
    check("fwd_pending", 64'(0), 64'(rs1_valid_o));
    @(negedge clk_i);
    // ids out of order with one on each port
    drive_wb(0, 3'd2, d2);
    drive_wb(1, 3'd1, d1);
    rs1_i = 5'd5;
    rs2_i = 5'd4;
    #1;
    check("fwd_wb", 64'(1), 64'({rs1_valid_o, rs2_valid_o} == 2'b11));
    check("fwd_wb_rs1", d2, rs1_o);
    check("fwd_wb_rs2", d1, rs2_o);
    @(negedge clk_i);
    wb_valid_i = '0;
    #1;
    check("fwd_done", 64'(1), 64'({rs1_valid_o, rs2_valid_o} == 2'b11));
    check("fwd_done_rs1", d2, rs1_o);
    check("fwd_done_rs2", d1, rs2_o);
    // x9 writer still waiting on the alu
    rs2_i = 5'd9;
    #1;
    check("fwd_unfinished", 64'(0), 64'(rs2_valid_o));
    @(negedge clk_i);
    drive_wb(0, 3'd5, d5);
    drive_wb(1, 3'd3, d3);
    @(negedge clk_i);
    wb_valid_i = '0;
    commit_op("commit", 3'd1, sb_pkg::FU_LSU, 5'd4, 1'b1, d1);
    commit_op("commit", 3'd2, sb_pkg::FU_MULT, 5'd5, 1'b1, d2);
    commit_op("commit", 3'd3, sb_pkg::FU_ALU, 5'd0, 1'b1, d3);
    commit_op("commit_none", 3'd4, sb_pkg::FU_NONE, 5'd6, 1'b0, '0);
    commit_op("commit", 3'd5, sb_pkg::FU_ALU, 5'd9, 1'b1, d5);
    commit_op("commit_none", 3'd6, sb_pkg::FU_NONE, 5'd7, 1'b0, '0);
  endtask

  task automatic test_branch();
    logic [ID_W-1:0] id;
    unresolved_branch_i = 1'b1;
    decoded_valid_i = 1'b1;
    decoded_fu_i = sb_pkg::FU_ALU;
    decoded_rd_i = 5'd10;
    #1;
    check("branch", 64'(0), 64'(issue_valid_o));
    @(negedge clk_i);
    unresolved_branch_i = 1'b0;
    #1;
    check("branch_release", 64'(1), 64'(issue_valid_o));
    // seven allocations so far put the allocate pointer at slot 7
    check("branch_release_id", 64'(7), 64'(issue_trans_id_o));
    // handshake fires but the instruction is dropped
    issue_ack_i = 1'b1;
    flush_unissued_i = 1'b1;
    @(negedge clk_i);
    issue_ack_i = 1'b0;
    flush_unissued_i = 1'b0;
    decoded_valid_i = 1'b0;
    #1;
    check("flush_unissued", 64'(sb_pkg::FU_NONE), 64'(rd_clobber_o[10]));
    @(negedge clk_i);
    issue_op(sb_pkg::FU_ALU, 5'd10, id);
    check("flush_unissued_id", 64'(7), 64'(id));
  endtask

  task automatic test_flush();
    logic [ID_W-1:0] id;
    check("flush_before", 64'(sb_pkg::FU_ALU), 64'(rd_clobber_o[10]));
    drive_wb(0, 3'd7, rand_data());
    @(negedge clk_i);
    wb_valid_i = '0;
    #1;
    check("flush_before", 64'(1), 64'(commit_valid_o));
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    #1;
    check("flush", 64'(0), 64'(commit_valid_o));
    check_all_free("flush");
    @(negedge clk_i);
    issue_op(sb_pkg::FU_BRANCH, 5'd12, id);
    check("flush_id", 64'(0), 64'(id));
  endtask

  initial begin
    rst_ni = 1'b0;
    decoded_valid_i = 1'b0;
    decoded_fu_i = sb_pkg::FU_NONE;
    decoded_rd_i = '0;
    issue_ack_i = 1'b0;
    unresolved_branch_i = 1'b0;
    wb_valid_i = '0;
    wb_trans_id_i = '0;
    wb_data_i = '0;
    commit_ack_i = 1'b0;
    rs1_i = '0;
    rs2_i = '0;
    flush_i = 1'b0;
    flush_unissued_i = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset();
    @(negedge clk_i);
    test_alloc();
    test_full();
    test_writeback();
    test_branch();
    test_flush();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- source/scoreboard.sv
// instruction scoreboard
// in-order allocate and commit, out-of-order write-back, integer registers
// clobber table and operand forwarding for the issue stage
`timescale 1ns/100ps

module scoreboard #(
  parameter int unsigned NR_ENTRIES = 8,
  parameter int unsigned NR_WB_PORTS = 2,
  localparam int unsigned ID_W = $clog2(NR_ENTRIES)
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // decode handshake
  input  logic                                 decoded_valid_i,
  input  sb_pkg::fu_t                          decoded_fu_i,
  input  sb_pkg::reg_addr_t                    decoded_rd_i,
  output logic                                 decoded_ack_o,
  // issue handshake
  output logic                                 issue_valid_o,
  output sb_pkg::fu_t                          issue_fu_o,
  output sb_pkg::reg_addr_t                    issue_rd_o,
  output logic [ID_W-1:0]                      issue_trans_id_o,
  input  logic                                 issue_ack_i,
  input  logic                                 unresolved_branch_i,
  // write-back ports
  input  logic [NR_WB_PORTS-1:0]               wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][ID_W-1:0]     wb_trans_id_i,
  input  sb_pkg::data_t [NR_WB_PORTS-1:0]      wb_data_i,
  // commit port
  output logic                                 commit_valid_o,
  output sb_pkg::fu_t                          commit_fu_o,
  output sb_pkg::reg_addr_t                    commit_rd_o,
  output sb_pkg::data_t                        commit_result_o,
  output logic [ID_W-1:0]                      commit_trans_id_o,
  input  logic                                 commit_ack_i,
  // operand read ports
  input  sb_pkg::reg_addr_t                    rs1_i,
  input  sb_pkg::reg_addr_t                    rs2_i,
  output sb_pkg::data_t                        rs1_o,
  output sb_pkg::data_t                        rs2_o,
  output logic                                 rs1_valid_o,
  output logic                                 rs2_valid_o,
  // status and flush
  output sb_pkg::fu_t [sb_pkg::NR_REGS-1:0]    rd_clobber_o,
  output logic                                 sb_full_o,
  input  logic                                 flush_i,
  input  logic                                 flush_unissued_i
);

  logic                               alloc_en, commit_en, clear;
  logic [ID_W-1:0]                    alloc_idx, commit_idx;
  logic [NR_ENTRIES-1:0]              issued, done;
  sb_pkg::fu_t [NR_ENTRIES-1:0]       fu;
  sb_pkg::reg_addr_t [NR_ENTRIES-1:0] rd;
  sb_pkg::data_t [NR_ENTRIES-1:0]     result;

  sb_ctrl #(.NR_ENTRIES(NR_ENTRIES)) i_ctrl (
    .clk_i, .rst_ni, .decoded_valid_i, .issue_ack_i, .unresolved_branch_i,
    .flush_i, .flush_unissued_i, .commit_ack_i, .issue_valid_o, .decoded_ack_o,
    .sb_full_o, .alloc_en_o(alloc_en), .commit_en_o(commit_en), .clear_o(clear),
    .alloc_idx_o(alloc_idx), .commit_idx_o(commit_idx)
  );

  sb_entry_store #(.NR_ENTRIES(NR_ENTRIES), .NR_WB_PORTS(NR_WB_PORTS)) i_store (
    .clk_i, .rst_ni, .alloc_en_i(alloc_en), .alloc_idx_i(alloc_idx),
    .alloc_fu_i(decoded_fu_i), .alloc_rd_i(decoded_rd_i), .commit_en_i(commit_en),
    .commit_idx_i(commit_idx), .clear_i(clear), .wb_valid_i, .wb_trans_id_i,
    .wb_data_i, .issued_o(issued), .done_o(done), .fu_o(fu), .rd_o(rd),
    .result_o(result)
  );

  sb_clobber #(.NR_ENTRIES(NR_ENTRIES)) i_clobber (
    .issued_i(issued), .fu_i(fu), .rd_i(rd), .rd_clobber_o
  );

  sb_operand_fwd #(.NR_ENTRIES(NR_ENTRIES), .NR_WB_PORTS(NR_WB_PORTS)) i_fwd (
    .rs1_i, .rs2_i, .wb_valid_i, .wb_trans_id_i, .wb_data_i, .issued_i(issued),
    .done_i(done), .rd_i(rd), .result_i(result), .rs1_o, .rs2_o, .rs1_valid_o,
    .rs2_valid_o
  );

  // -------------------------------------------------------------------------
  // issue and commit outputs
  // -------------------------------------------------------------------------
  // decoded instruction passes straight through, stamped with its slot
  assign issue_fu_o = decoded_fu_i;
  assign issue_rd_o = decoded_rd_i;
  assign issue_trans_id_o = alloc_idx;

  // oldest entry, ready once it has its result
  assign commit_valid_o = issued[commit_idx] & done[commit_idx];
  assign commit_fu_o = fu[commit_idx];
  assign commit_rd_o = rd[commit_idx];
  assign commit_result_o = result[commit_idx];
  assign commit_trans_id_o = commit_idx;

endmodule

//--- source/sb_operand_fwd.sv
// operand forwarding
// two read ports served from the write-back ports or finished entries
`timescale 1ns/100ps

module sb_operand_fwd #(
  parameter int unsigned NR_ENTRIES = 8,
  parameter int unsigned NR_WB_PORTS = 2,
  localparam int unsigned ID_W = $clog2(NR_ENTRIES)
) (
  input  sb_pkg::reg_addr_t                    rs1_i,
  input  sb_pkg::reg_addr_t                    rs2_i,
  input  logic [NR_WB_PORTS-1:0]               wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][ID_W-1:0]     wb_trans_id_i,
  input  sb_pkg::data_t [NR_WB_PORTS-1:0]      wb_data_i,
  input  logic [NR_ENTRIES-1:0]                issued_i,
  input  logic [NR_ENTRIES-1:0]                done_i,
  input  sb_pkg::reg_addr_t [NR_ENTRIES-1:0]   rd_i,
  input  sb_pkg::data_t [NR_ENTRIES-1:0]       result_i,
  output sb_pkg::data_t                        rs1_o,
  output sb_pkg::data_t                        rs2_o,
  output logic                                 rs1_valid_o,
  output logic                                 rs2_valid_o
);

  // hit flag on top, data below
  function automatic logic [sb_pkg::XLEN:0] fwd_lookup(input sb_pkg::reg_addr_t rs);
    logic          hit;
    sb_pkg::data_t data;
    hit = 1'b0;
    data = '0;
    // finished entries, lowest index last so it wins
    for (int i = int'(NR_ENTRIES) - 1; i >= 0; i--) begin
      if (issued_i[i] && done_i[i] && rd_i[i] == rs) begin
        hit = 1'b1;
        data = result_i[i];
      end
    end
    // results on the write-back ports override the stored ones
    // the target entry gives the destination register
    for (int p = int'(NR_WB_PORTS) - 1; p >= 0; p--) begin
      if (wb_valid_i[p] && issued_i[wb_trans_id_i[p]] && rd_i[wb_trans_id_i[p]] == rs) begin
        hit = 1'b1;
        data = wb_data_i[p];
      end
    end
    // x0 reads come from the register file
    return {hit & (rs != '0), data};
  endfunction

  always_comb begin
    {rs1_valid_o, rs1_o} = fwd_lookup(rs1_i);
    {rs2_valid_o, rs2_o} = fwd_lookup(rs2_i);
  end

endmodule

//--- source/sb_clobber.sv
// register clobber table
// unit that will write each integer register with the lowest entry winning
`timescale 1ns/100ps

module sb_clobber #(
  parameter int unsigned NR_ENTRIES = 8
) (
  input  logic [NR_ENTRIES-1:0]                  issued_i,
  input  sb_pkg::fu_t [NR_ENTRIES-1:0]           fu_i,
  input  sb_pkg::reg_addr_t [NR_ENTRIES-1:0]     rd_i,
  output sb_pkg::fu_t [sb_pkg::NR_REGS-1:0]      rd_clobber_o
);

  always_comb begin
    // no pending writer by default
    for (int r = 0; r < int'(sb_pkg::NR_REGS); r++) begin
      rd_clobber_o[r] = sb_pkg::FU_NONE;
    end
    // walk from the top so the lowest issued entry is written last
    for (int i = int'(NR_ENTRIES) - 1; i >= 0; i--) begin
      if (issued_i[i]) begin
        rd_clobber_o[rd_i[i]] = fu_i[i];
      end
    end
    // x0 is hard-wired and never busy
    rd_clobber_o[0] = sb_pkg::FU_NONE;
  end

endmodule

//--- source/sb_entry_store.sv
// scoreboard entry array
// issued and done bits, unit, destination and result per entry
// updated by allocation, self-completion, write-back, commit and clear
`timescale 1ns/100ps

module sb_entry_store #(
  parameter int unsigned NR_ENTRIES = 8,
  parameter int unsigned NR_WB_PORTS = 2,
  localparam int unsigned ID_W = $clog2(NR_ENTRIES)
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    alloc_en_i,
  input  logic [ID_W-1:0]                         alloc_idx_i,
  input  sb_pkg::fu_t                             alloc_fu_i,
  input  sb_pkg::reg_addr_t                       alloc_rd_i,
  input  logic                                    commit_en_i,
  input  logic [ID_W-1:0]                         commit_idx_i,
  input  logic                                    clear_i,
  input  logic [NR_WB_PORTS-1:0]                  wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][ID_W-1:0]        wb_trans_id_i,
  input  sb_pkg::data_t [NR_WB_PORTS-1:0]         wb_data_i,
  output logic [NR_ENTRIES-1:0]                   issued_o,
  output logic [NR_ENTRIES-1:0]                   done_o,
  output sb_pkg::fu_t [NR_ENTRIES-1:0]            fu_o,
  output sb_pkg::reg_addr_t [NR_ENTRIES-1:0]      rd_o,
  output sb_pkg::data_t [NR_ENTRIES-1:0]          result_o
);

  logic [NR_ENTRIES-1:0]              issued_q, issued_n;
  logic [NR_ENTRIES-1:0]              done_q, done_n;
  sb_pkg::fu_t [NR_ENTRIES-1:0]       fu_q;
  sb_pkg::reg_addr_t [NR_ENTRIES-1:0] rd_q;
  sb_pkg::data_t [NR_ENTRIES-1:0]     result_q;

  // -------------------------------------------------------------------------
  // status bit next state
  // -------------------------------------------------------------------------
  always_comb begin
    issued_n = issued_q;
    done_n = done_q;

    // new entry, result still pending
    if (alloc_en_i) begin
      issued_n[alloc_idx_i] = 1'b1;
      done_n[alloc_idx_i] = 1'b0;
    end

    // no unit to wait for, done one cycle after it shows up
    for (int i = 0; i < int'(NR_ENTRIES); i++) begin
      if (issued_q[i] && fu_q[i] == sb_pkg::FU_NONE) begin
        done_n[i] = 1'b1;
      end
    end

    // late write-backs to freed or flushed entries are dropped
    for (int p = 0; p < int'(NR_WB_PORTS); p++) begin
      if (wb_valid_i[p] && issued_q[wb_trans_id_i[p]]) begin
        done_n[wb_trans_id_i[p]] = 1'b1;
      end
    end

    // commit frees the oldest entry
    if (commit_en_i) begin
      issued_n[commit_idx_i] = 1'b0;
      done_n[commit_idx_i] = 1'b0;
    end

    if (clear_i) begin
      issued_n = '0;
      done_n = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q <= '0;
      done_q <= '0;
    end else begin
      issued_q <= issued_n;
      done_q <= done_n;
    end
  end

  // -------------------------------------------------------------------------
  // payload
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (alloc_en_i) begin
      fu_q[alloc_idx_i] <= alloc_fu_i;
      rd_q[alloc_idx_i] <= alloc_rd_i;
    end
    for (int p = 0; p < int'(NR_WB_PORTS); p++) begin
      if (wb_valid_i[p] && issued_q[wb_trans_id_i[p]]) begin
        result_q[wb_trans_id_i[p]] <= wb_data_i[p];
      end
    end
  end

  assign issued_o = issued_q;
  assign done_o = done_q;
  assign fu_o = fu_q;
  assign rd_o = rd_q;
  assign result_o = result_q;

  // commit stage only frees a finished entry
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_en_i |-> (issued_q[commit_idx_i] && done_q[commit_idx_i]))
    else $error("commit of an unfinished entry");

  // each functional unit owns its own transaction ids
  for (genvar i = 0; i < NR_WB_PORTS; i++) begin : g_wb_chk
    for (genvar j = i + 1; j < NR_WB_PORTS; j++) begin : g_pair
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_valid_i[i] && wb_valid_i[j]) |-> (wb_trans_id_i[i] != wb_trans_id_i[j]))
        else $error("two write-back ports carry the same id");
    end
  end

endmodule

//--- source/sb_ctrl.sv
// scoreboard control
// allocate and commit pointers, occupancy count, full and flush handling
`timescale 1ns/100ps

module sb_ctrl #(
  parameter int unsigned NR_ENTRIES = 8,
  localparam int unsigned ID_W = $clog2(NR_ENTRIES)
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            decoded_valid_i,
  input  logic            issue_ack_i,
  input  logic            unresolved_branch_i,
  input  logic            flush_i,
  input  logic            flush_unissued_i,
  input  logic            commit_ack_i,
  output logic            issue_valid_o,
  output logic            decoded_ack_o,
  output logic            sb_full_o,
  output logic            alloc_en_o,
  output logic            commit_en_o,
  output logic            clear_o,
  output logic [ID_W-1:0] alloc_idx_o,
  output logic [ID_W-1:0] commit_idx_o
);

  // one extra bit so an underflow of the count stays visible
  localparam int unsigned CNT_W = ID_W + 1;

  logic [ID_W-1:0]  alloc_ptr_q;
  logic [ID_W-1:0]  commit_ptr_q;
  logic [CNT_W-1:0] count_q;

  // -------------------------------------------------------------------------
  // handshakes and enables
  // -------------------------------------------------------------------------
  // full leaves one slot empty
  assign sb_full_o = (count_q == CNT_W'(NR_ENTRIES - 1));

  // no issue while a branch is unresolved or the queue is full
  assign issue_valid_o = decoded_valid_i & ~unresolved_branch_i & ~sb_full_o;
  assign decoded_ack_o = issue_ack_i & ~sb_full_o;

  // an unissued flush drops the instruction in the handshake cycle
  assign alloc_en_o = decoded_valid_i & decoded_ack_o & ~flush_unissued_i & ~flush_i;
  assign commit_en_o = commit_ack_i & ~flush_i;
  assign clear_o = flush_i;

  assign alloc_idx_o = alloc_ptr_q;
  assign commit_idx_o = commit_ptr_q;

  // -------------------------------------------------------------------------
  // pointer and count registers
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alloc_ptr_q <= '0;
      commit_ptr_q <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      alloc_ptr_q <= '0;
      commit_ptr_q <= '0;
      count_q <= '0;
    end else begin
      // pointers wrap at the power-of-two depth
      alloc_ptr_q <= alloc_ptr_q + ID_W'(alloc_en_o);
      commit_ptr_q <= commit_ptr_q + ID_W'(commit_en_o);
      count_q <= count_q + CNT_W'(alloc_en_o) - CNT_W'(commit_en_o);
    end
  end

  // issue stage only acknowledges an offered instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni) issue_ack_i |-> issue_valid_o)
    else $error("issue acknowledged without a valid instruction");

  // a commit from an empty queue would wrap the count
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CNT_W'(NR_ENTRIES - 1))
    else $error("occupancy above the queue depth");

endmodule

//--- source/sb_pkg.sv
// scoreboard package
// register, data and functional-unit types shared by the scoreboard blocks
package sb_pkg;

  // -------------------------------------------------------------------------
  // register file geometry
  // -------------------------------------------------------------------------
  // integer register address width
  localparam int unsigned REG_ADDR_W = 5;
  // number of architectural integer registers
  localparam int unsigned NR_REGS = 2 ** REG_ADDR_W;
  // operand and result width
  localparam int unsigned XLEN = 64;

  // register address
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  // operand or result value
  typedef logic [XLEN-1:0] data_t;
  // functional-unit code
  typedef logic [2:0] fu_t;

  // -------------------------------------------------------------------------
  // functional-unit codes
  // -------------------------------------------------------------------------
  // no unit needed, the entry completes by itself
  // also the clobber value of a register without a pending writer
  localparam fu_t FU_NONE = 3'd0;
  // integer alu
  localparam fu_t FU_ALU = 3'd1;
  // load/store unit
  localparam fu_t FU_LSU = 3'd2;
  // multiplier/divider
  localparam fu_t FU_MULT = 3'd3;
  // branch unit
  localparam fu_t FU_BRANCH = 3'd4;

endpackage
